// File: hdl/core_pkg.sv
/* core widths, depths and encodings */

`default_nettype none

package core_pkg;

	////////////////////////////////////////
	// datapath and register file
	////////////////////////////////////////

	localparam int XLEN      = 32;
	localparam int ARCH_REGS = 8;
	localparam int REG_IDX_W = 3;

	////////////////////////////////////////
	// rename and scheduling structures
	////////////////////////////////////////

	localparam int ROB_DEPTH = 8;
	localparam int ROB_TAG_W = 3;
	localparam int RS_DEPTH  = 4;
	// slot index and age width in the RS
	localparam int RS_IDX_W  = $clog2(RS_DEPTH);

	// multiply latency, issue edge to CDB
	localparam int MUL_CYCLES = 4;
	localparam int MUL_CNT_W  = $clog2(MUL_CYCLES);
	// multiplier bits retired per cycle
	localparam int MUL_CHUNK  = XLEN / MUL_CYCLES;

	// opcode sits in inst[31:28]
	typedef enum logic [3:0] {
		OP_LI,
		OP_ADD,
		OP_SUB,
		OP_AND,
		OP_OR,
		OP_XOR,
		OP_SLL,
		OP_SRL,
		OP_MUL
	} opcode_t;

	// execution unit FSM
	typedef enum logic {
		EX_IDLE,
		EX_MUL_BUSY
	} exec_state_t;

endpackage

`default_nettype wire

// File: hdl/dispatch_stage.sv
/* decode and dispatch register */

`timescale 1ns/10ps
`default_nettype none

module dispatch_stage (
	input  wire                            clock,
	input  wire                            reset,
	input  wire                            inst_valid,
	input  wire  [31:0]                    inst,
	input  wire                            rob_full,
	input  wire                            rs_full,
	output logic                           inst_ready,
	output logic                           disp_valid,
	output logic                           disp_fire,
	output core_pkg::opcode_t              disp_op,
	output logic [core_pkg::REG_IDX_W-1:0] disp_rd,
	output logic [core_pkg::REG_IDX_W-1:0] disp_rs1,
	output logic [core_pkg::REG_IDX_W-1:0] disp_rs2,
	output logic [core_pkg::XLEN-1:0]      disp_imm
);
	import core_pkg::*;

	opcode_t         dec_op;
	logic [XLEN-1:0] dec_imm;

	// leaves only when ROB and RS both have a free slot
	assign disp_fire  = disp_valid && !rob_full && !rs_full;
	// empty slot, or the held one leaves this edge
	assign inst_ready = !disp_valid || disp_fire;

	// opcode check, unknown codes become li 0
	always_comb begin
		dec_op  = OP_LI;
		dec_imm = {{(XLEN-16){inst[15]}}, inst[15:0]};
		case (inst[31:28])
			OP_LI, OP_ADD, OP_SUB, OP_AND, OP_OR,
			OP_XOR, OP_SLL, OP_SRL, OP_MUL: dec_op = opcode_t'(inst[31:28]);
			default: dec_imm = '0;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			disp_valid <= 1'b0;
		end else if (inst_ready) begin
			disp_valid <= inst_valid;
		end
	end

	// decoded fields
	always_ff @(posedge clock) begin
		if (inst_ready) begin
			disp_op  <= dec_op;
			disp_rd  <= inst[27:25];
			disp_rs1 <= inst[24:22];
			disp_rs2 <= inst[21:19];
			disp_imm <= dec_imm;
		end
	end

	// a stalled instruction stays put
	a_hold_stalled: assert property (@(posedge clock) disable iff (reset)
		disp_valid && !disp_fire |=> disp_valid &&
		$stable({disp_op, disp_rd, disp_rs1, disp_rs2, disp_imm}));

endmodule

`default_nettype wire

// File: hdl/map_table.sv
/* register rename table */

`timescale 1ns/10ps
`default_nettype none

module map_table (
	input  wire                            clock,
	input  wire                            reset,
	input  wire                            disp_fire,
	input  wire  [core_pkg::REG_IDX_W-1:0] disp_rd,
	input  wire  [core_pkg::ROB_TAG_W-1:0] disp_tag,
	input  wire  [core_pkg::REG_IDX_W-1:0] disp_rs1,
	input  wire  [core_pkg::REG_IDX_W-1:0] disp_rs2,
	input  wire                            commit_valid,
	input  wire  [core_pkg::REG_IDX_W-1:0] commit_rd,
	input  wire  [core_pkg::ROB_TAG_W-1:0] commit_tag,
	output logic                           rs1_busy,
	output logic [core_pkg::ROB_TAG_W-1:0] rs1_tag,
	output logic                           rs2_busy,
	output logic [core_pkg::ROB_TAG_W-1:0] rs2_tag
);
	import core_pkg::*;

	// busy means the newest writer is still in flight
	logic [ARCH_REGS-1:0] busy;
	logic [ROB_TAG_W-1:0] tag [ARCH_REGS];

	// source lookup sees the table before this rename
	assign rs1_busy = busy[disp_rs1];
	assign rs1_tag  = tag[disp_rs1];
	assign rs2_busy = busy[disp_rs2];
	assign rs2_tag  = tag[disp_rs2];

	always_ff @(posedge clock) begin
		if (reset) begin
			busy <= '0;
		end else begin
			// only the newest writer may release the register
			if (commit_valid && busy[commit_rd] && (tag[commit_rd] == commit_tag))
				busy[commit_rd] <= 1'b0;
			// rename wins over the clear
			if (disp_fire)
				busy[disp_rd] <= 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (disp_fire)
			tag[disp_rd] <= disp_tag;
	end

endmodule

`default_nettype wire

// File: hdl/reservation_station.sv
/* reservation station */

`timescale 1ns/10ps
`default_nettype none

module reservation_station (
	input  wire                            clock,
	input  wire                            reset,
	input  wire                            disp_fire,
	input  wire  core_pkg::opcode_t        disp_op,
	input  wire  [core_pkg::XLEN-1:0]      disp_imm,
	input  wire  [core_pkg::ROB_TAG_W-1:0] disp_tag,
	input  wire                            src1_ready,
	input  wire  [core_pkg::XLEN-1:0]      src1_value,
	input  wire  [core_pkg::ROB_TAG_W-1:0] src1_tag,
	input  wire                            src2_ready,
	input  wire  [core_pkg::XLEN-1:0]      src2_value,
	input  wire  [core_pkg::ROB_TAG_W-1:0] src2_tag,
	input  wire                            cdb_valid,
	input  wire  [core_pkg::ROB_TAG_W-1:0] cdb_tag,
	input  wire  [core_pkg::XLEN-1:0]      cdb_value,
	input  wire                            exec_busy,
	output logic                           rs_full,
	output logic                           issue_valid,
	output core_pkg::opcode_t              issue_op,
	output logic [core_pkg::XLEN-1:0]      issue_a,
	output logic [core_pkg::XLEN-1:0]      issue_b,
	output logic [core_pkg::XLEN-1:0]      issue_imm,
	output logic [core_pkg::ROB_TAG_W-1:0] issue_tag
);
	import core_pkg::*;

	logic [RS_DEPTH-1:0]  valid, a_rdy, b_rdy, ready_vec;
	opcode_t              op      [RS_DEPTH];
	logic [XLEN-1:0]      imm     [RS_DEPTH];
	logic [XLEN-1:0]      a_val   [RS_DEPTH];
	logic [XLEN-1:0]      b_val   [RS_DEPTH];
	logic [ROB_TAG_W-1:0] a_tag   [RS_DEPTH];
	logic [ROB_TAG_W-1:0] b_tag   [RS_DEPTH];
	logic [ROB_TAG_W-1:0] dest    [RS_DEPTH];
	// age 0 is the oldest, ages stay packed 0..n-1
	logic [RS_IDX_W-1:0]  age     [RS_DEPTH];
	logic [RS_IDX_W-1:0]  free_idx, issue_sel;
	logic [RS_IDX_W:0]    n_valid;
	logic                 found;

	assign ready_vec = valid & a_rdy & b_rdy;
	assign rs_full   = &valid;

	// free slot, occupancy and oldest ready entry
	always_comb begin
		free_idx  = '0;
		issue_sel = '0;
		n_valid   = '0;
		found     = 1'b0;
		for (int i = RS_DEPTH - 1; i >= 0; i--) begin
			if (!valid[i])
				free_idx = RS_IDX_W'(i);
			n_valid = n_valid + (RS_IDX_W+1)'(valid[i]);
		end
		for (int i = 0; i < RS_DEPTH; i++) begin
			if (ready_vec[i] && (!found || age[i] < age[issue_sel])) begin
				issue_sel = RS_IDX_W'(i);
				found     = 1'b1;
			end
		end
	end

	assign issue_valid = found && !exec_busy;
	assign issue_op    = op[issue_sel];
	assign issue_a     = a_val[issue_sel];
	assign issue_b     = b_val[issue_sel];
	assign issue_imm   = imm[issue_sel];
	assign issue_tag   = dest[issue_sel];

	always_ff @(posedge clock) begin
		if (reset) begin
			valid <= '0;
		end else begin
			// wake waiting operands from the CDB
			for (int i = 0; i < RS_DEPTH; i++) begin
				if (valid[i] && cdb_valid && !a_rdy[i] && a_tag[i] == cdb_tag) begin
					a_rdy[i] <= 1'b1;
					a_val[i] <= cdb_value;
				end
				if (valid[i] && cdb_valid && !b_rdy[i] && b_tag[i] == cdb_tag) begin
					b_rdy[i] <= 1'b1;
					b_val[i] <= cdb_value;
				end
				// close the age gap left by the issued entry
				if (issue_valid && age[i] > age[issue_sel])
					age[i] <= age[i] - 1'b1;
			end
			if (issue_valid)
				valid[issue_sel] <= 1'b0;
			if (disp_fire) begin
				valid[free_idx] <= 1'b1;
				op[free_idx]    <= disp_op;
				imm[free_idx]   <= disp_imm;
				dest[free_idx]  <= disp_tag;
				age[free_idx]   <= RS_IDX_W'(n_valid - (RS_IDX_W+1)'(issue_valid));
				// a producer on the CDB right now is caught here
				a_rdy[free_idx] <= src1_ready || (cdb_valid && cdb_tag == src1_tag);
				a_val[free_idx] <= src1_ready ? src1_value : cdb_value;
				a_tag[free_idx] <= src1_tag;
				b_rdy[free_idx] <= src2_ready || (cdb_valid && cdb_tag == src2_tag);
				b_val[free_idx] <= src2_ready ? src2_value : cdb_value;
				b_tag[free_idx] <= src2_tag;
			end
		end
	end

	// a write into a full RS would overwrite a live entry
	a_no_alloc_full: assert property (@(posedge clock) disable iff (reset)
		disp_fire |-> !rs_full);

endmodule

`default_nettype wire

// File: hdl/exec_unit.sv
/* ALU and multiplier */

`timescale 1ns/10ps
`default_nettype none

module exec_unit (
	input  wire                            clock,
	input  wire                            reset,
	input  wire                            issue_valid,
	input  wire  core_pkg::opcode_t        issue_op,
	input  wire  [core_pkg::XLEN-1:0]      issue_a,
	input  wire  [core_pkg::XLEN-1:0]      issue_b,
	input  wire  [core_pkg::XLEN-1:0]      issue_imm,
	input  wire  [core_pkg::ROB_TAG_W-1:0] issue_tag,
	output logic                           exec_busy,
	output logic                           cdb_valid,
	output logic [core_pkg::ROB_TAG_W-1:0] cdb_tag,
	output logic [core_pkg::XLEN-1:0]      cdb_value
);
	import core_pkg::*;

	exec_state_t          state;
	logic [MUL_CNT_W-1:0] mul_cnt;
	logic [XLEN-1:0]      alu_result, mul_acc, mul_a, mul_b, mul_step;

	assign exec_busy = (state == EX_MUL_BUSY);
	// one multiplier chunk per cycle, low XLEN bits only
	assign mul_step  = mul_a * mul_b[MUL_CHUNK-1:0];

	always_comb begin
		case (issue_op)
			OP_ADD:  alu_result = issue_a + issue_b;
			OP_SUB:  alu_result = issue_a - issue_b;
			OP_AND:  alu_result = issue_a & issue_b;
			OP_OR:   alu_result = issue_a | issue_b;
			OP_XOR:  alu_result = issue_a ^ issue_b;
			OP_SLL:  alu_result = issue_a << issue_b[4:0];
			OP_SRL:  alu_result = issue_a >> issue_b[4:0];
			default: alu_result = issue_imm;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state     <= EX_IDLE;
			mul_cnt   <= '0;
			cdb_valid <= 1'b0;
		end else begin
			cdb_valid <= 1'b0;
			if (state == EX_IDLE && issue_valid && issue_op == OP_MUL) begin
				state   <= EX_MUL_BUSY;
				// issue edge takes chunk 0
				mul_cnt <= MUL_CNT_W'(MUL_CYCLES - 2);
			end else if (state == EX_IDLE && issue_valid) begin
				cdb_valid <= 1'b1;
			end else if (state == EX_MUL_BUSY) begin
				mul_cnt <= mul_cnt - 1'b1;
				if (mul_cnt == '0) begin
					state     <= EX_IDLE;
					cdb_valid <= 1'b1;
				end
			end
		end
	end

	// result and multiplier datapath
	always_ff @(posedge clock) begin
		if (state == EX_IDLE && issue_valid) begin
			cdb_tag   <= issue_tag;
			cdb_value <= alu_result;
			mul_acc   <= issue_a * issue_b[MUL_CHUNK-1:0];
			mul_a     <= issue_a << MUL_CHUNK;
			mul_b     <= issue_b >> MUL_CHUNK;
		end else if (state == EX_MUL_BUSY) begin
			mul_acc   <= mul_acc + mul_step;
			mul_a     <= mul_a << MUL_CHUNK;
			mul_b     <= mul_b >> MUL_CHUNK;
			// last chunk goes straight onto the CDB
			cdb_value <= mul_acc + mul_step;
		end
	end

	// RS must hold off while a multiply is in flight
	a_no_issue_busy: assert property (@(posedge clock) disable iff (reset)
		issue_valid |-> state == EX_IDLE);

endmodule

`default_nettype wire

// File: hdl/reorder_buffer.sv
/* reorder buffer */

`timescale 1ns/10ps
`default_nettype none

module reorder_buffer (
	input  wire                            clock,
	input  wire                            reset,
	input  wire                            disp_fire,
	input  wire  [core_pkg::REG_IDX_W-1:0] disp_rd,
	input  wire                            cdb_valid,
	input  wire  [core_pkg::ROB_TAG_W-1:0] cdb_tag,
	input  wire  [core_pkg::XLEN-1:0]      cdb_value,
	input  wire  [core_pkg::ROB_TAG_W-1:0] look1_tag,
	input  wire  [core_pkg::ROB_TAG_W-1:0] look2_tag,
	output logic                           rob_full,
	output logic [core_pkg::ROB_TAG_W-1:0] tail_tag,
	output logic                           look1_done,
	output logic [core_pkg::XLEN-1:0]      look1_value,
	output logic                           look2_done,
	output logic [core_pkg::XLEN-1:0]      look2_value,
	output logic                           commit_valid,
	output logic [core_pkg::REG_IDX_W-1:0] commit_rd,
	output logic [core_pkg::XLEN-1:0]      commit_value,
	output logic [core_pkg::ROB_TAG_W-1:0] commit_tag
);
	import core_pkg::*;

	////////////////////////////////////////
	// pointers and entry state
	////////////////////////////////////////

	// pointers wrap on their own, depth is a power of two
	logic [ROB_TAG_W-1:0] head, tail;
	logic [ROB_TAG_W:0]   count;
	logic [ROB_DEPTH-1:0] done;
	logic [REG_IDX_W-1:0] rd_q    [ROB_DEPTH];
	logic [XLEN-1:0]      value_q [ROB_DEPTH];

	// full check ignores a commit on the same edge
	assign rob_full = (count == (ROB_TAG_W+1)'(ROB_DEPTH));
	assign tail_tag = tail;

	// operand forwarding for dispatch
	assign look1_done  = done[look1_tag];
	assign look1_value = value_q[look1_tag];
	assign look2_done  = done[look2_tag];
	assign look2_value = value_q[look2_tag];

	////////////////////////////////////////
	// in-order retire
	////////////////////////////////////////

	assign commit_valid = (count != '0) && done[head];
	assign commit_rd    = rd_q[head];
	assign commit_value = value_q[head];
	assign commit_tag   = head;

	always_ff @(posedge clock) begin
		if (reset) begin
			head  <= '0;
			tail  <= '0;
			count <= '0;
			done  <= '0;
		end else begin
			if (disp_fire) begin
				done[tail] <= 1'b0;
				tail       <= tail + 1'b1;
			end
			// completion from the CDB
			if (cdb_valid)
				done[cdb_tag] <= 1'b1;
			if (commit_valid)
				head <= head + 1'b1;
			count <= count + (ROB_TAG_W+1)'(disp_fire) - (ROB_TAG_W+1)'(commit_valid);
		end
	end

	// destination and result storage
	always_ff @(posedge clock) begin
		if (disp_fire)
			rd_q[tail] <= disp_rd;
		if (cdb_valid)
			value_q[cdb_tag] <= cdb_value;
	end

	// dispatch must respect the full flag
	a_no_alloc_full: assert property (@(posedge clock) disable iff (reset)
		disp_fire |-> !rob_full);

endmodule

`default_nettype wire

// File: hdl/regfile.sv
/* architectural register file */

`timescale 1ns/10ps
`default_nettype none

module regfile (
	input  wire                            clock,
	input  wire                            reset,
	input  wire  [core_pkg::REG_IDX_W-1:0] rda_idx,
	input  wire  [core_pkg::REG_IDX_W-1:0] rdb_idx,
	input  wire                            wr_en,
	input  wire  [core_pkg::REG_IDX_W-1:0] wr_idx,
	input  wire  [core_pkg::XLEN-1:0]      wr_data,
	output logic [core_pkg::XLEN-1:0]      rda_out,
	output logic [core_pkg::XLEN-1:0]      rdb_out
);
	import core_pkg::*;

	logic [XLEN-1:0] regs [ARCH_REGS];

	// reads see state before this edge's commit
	assign rda_out = regs[rda_idx];
	assign rdb_out = regs[rdb_idx];

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < ARCH_REGS; i++)
				regs[i] <= '0;
		end else if (wr_en) begin
			regs[wr_idx] <= wr_data;
		end
	end

endmodule

`default_nettype wire

// File: hdl/ooo_core.sv
/* out-of-order core top level */

`timescale 1ns/10ps
`default_nettype none

module ooo_core (
	input  wire                            clock,
	input  wire                            reset,
	input  wire                            inst_valid,
	input  wire  [31:0]                    inst,
	output logic                           inst_ready,
	output logic                           commit_valid,
	output logic [core_pkg::REG_IDX_W-1:0] commit_rd,
	output logic [core_pkg::XLEN-1:0]      commit_value
);
	import core_pkg::*;

	// dispatch
	logic                 disp_valid, disp_fire, rob_full, rs_full;
	opcode_t              disp_op;
	logic [REG_IDX_W-1:0] disp_rd, disp_rs1, disp_rs2;
	logic [XLEN-1:0]      disp_imm;
	logic [ROB_TAG_W-1:0] tail_tag, commit_tag;
	// operand sources
	logic                 rs1_busy, rs2_busy, look1_done, look2_done;
	logic [ROB_TAG_W-1:0] rs1_tag, rs2_tag;
	logic [XLEN-1:0]      rda_out, rdb_out, look1_value, look2_value;
	logic                 src1_ready, src2_ready;
	logic [XLEN-1:0]      src1_value, src2_value;
	// issue and CDB
	logic                 issue_valid, exec_busy, cdb_valid;
	opcode_t              issue_op;
	logic [XLEN-1:0]      issue_a, issue_b, issue_imm, cdb_value;
	logic [ROB_TAG_W-1:0] issue_tag, cdb_tag;

	// not renamed reads the regfile, else the ROB
	assign src1_ready = !rs1_busy || look1_done;
	assign src1_value = rs1_busy ? look1_value : rda_out;
	assign src2_ready = !rs2_busy || look2_done;
	assign src2_value = rs2_busy ? look2_value : rdb_out;

	dispatch_stage i_dispatch (.clock, .reset, .inst_valid, .inst, .rob_full, .rs_full,
		.inst_ready, .disp_valid, .disp_fire, .disp_op, .disp_rd, .disp_rs1, .disp_rs2,
		.disp_imm);

	map_table i_map (.clock, .reset, .disp_fire, .disp_rd, .disp_tag(tail_tag), .disp_rs1,
		.disp_rs2, .commit_valid, .commit_rd, .commit_tag, .rs1_busy, .rs1_tag, .rs2_busy,
		.rs2_tag);

	regfile i_regfile (.clock, .reset, .rda_idx(disp_rs1), .rdb_idx(disp_rs2),
		.wr_en(commit_valid), .wr_idx(commit_rd), .wr_data(commit_value), .rda_out,
		.rdb_out);

	reservation_station i_rs (.clock, .reset, .disp_fire, .disp_op, .disp_imm,
		.disp_tag(tail_tag), .src1_ready, .src1_value, .src1_tag(rs1_tag), .src2_ready,
		.src2_value, .src2_tag(rs2_tag), .cdb_valid, .cdb_tag, .cdb_value, .exec_busy,
		.rs_full, .issue_valid, .issue_op, .issue_a, .issue_b, .issue_imm, .issue_tag);

	exec_unit i_exec (.clock, .reset, .issue_valid, .issue_op, .issue_a, .issue_b,
		.issue_imm, .issue_tag, .exec_busy, .cdb_valid, .cdb_tag, .cdb_value);

	reorder_buffer i_rob (.clock, .reset, .disp_fire, .disp_rd, .cdb_valid, .cdb_tag,
		.cdb_value, .look1_tag(rs1_tag), .look2_tag(rs2_tag), .rob_full, .tail_tag,
		.look1_done, .look1_value, .look2_done, .look2_value, .commit_valid, .commit_rd,
		.commit_value, .commit_tag);

endmodule

`default_nettype wire

// File: testbench/tb_clock_gen.sv
/* clock and reset generator */

`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen (
	output logic clock,
	output logic reset
);
	// 4 ns period
	localparam int HALF_PERIOD_NS = 2;
	localparam int RESET_CYCLES   = 8;

	initial begin
		clock = 1'b0;
		forever #(HALF_PERIOD_NS) clock = ~clock;
	end

	// release just after an edge, same as the other stimulus
	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clock);
		#1;
		reset = 1'b0;
	end

endmodule

`default_nettype wire

// File: testbench/tb_ooo_core.sv
/* out-of-order core testbench */

`timescale 1ns/10ps
`default_nettype none

module tb_ooo_core;
	import core_pkg::*;

	localparam int TIMEOUT_CYCLES = 200;

	logic                 clock, reset, inst_valid, inst_ready, commit_valid;
	logic [31:0]          inst;
	logic [REG_IDX_W-1:0] commit_rd;
	logic [XLEN-1:0]      commit_value;

	// architectural state in program order
	logic [XLEN-1:0]      model_regs [ARCH_REGS];
	// expected commits, oldest first
	logic [REG_IDX_W-1:0] exp_rd_q [$];
	logic [XLEN-1:0]      exp_val_q [$];
	string                test_name;
	int                   seed;
	int                   errors, timeouts, accepted_count, commit_count, stall_cycles;
	logic                 timed_out;

	tb_clock_gen i_clock_gen (.clock, .reset);

	ooo_core i_dut (.clock, .reset, .inst_valid, .inst, .inst_ready, .commit_valid,
		.commit_rd, .commit_value);

	////////////////////////////////////////
	// reference model
	////////////////////////////////////////

	function automatic logic [31:0] make_inst(input logic [3:0] code,
		input logic [REG_IDX_W-1:0] rd, input logic [REG_IDX_W-1:0] rs1,
		input logic [REG_IDX_W-1:0] rs2, input logic [15:0] imm);
		return {code, rd, rs1, rs2, 3'b000, imm};
	endfunction

	function automatic logic [XLEN-1:0] expected_result(input logic [3:0] code,
		input logic [XLEN-1:0] a, input logic [XLEN-1:0] b, input logic [XLEN-1:0] imm);
		logic [XLEN-1:0] result;
		case (code)
			OP_LI:   result = imm;
			OP_ADD:  result = a + b;
			OP_SUB:  result = a - b;
			OP_AND:  result = a & b;
			OP_OR:   result = a | b;
			OP_XOR:  result = a ^ b;
			OP_SLL:  result = a << b[4:0];
			OP_SRL:  result = a >> b[4:0];
			OP_MUL:  result = a * b;
			// unknown code acts as li 0
			default: result = '0;
		endcase
		return result;
	endfunction

	// runs once per accepted word, so queue order is program order
	task automatic record_expected(input logic [31:0] word);
		logic [REG_IDX_W-1:0] rd;
		logic [XLEN-1:0]      imm, result;
		rd     = word[27:25];
		imm    = {{(XLEN-16){word[15]}}, word[15:0]};
		result = expected_result(word[31:28], model_regs[word[24:22]],
			model_regs[word[21:19]], imm);
		model_regs[rd] = result;
		exp_rd_q.push_back(rd);
		exp_val_q.push_back(result);
	endtask

	////////////////////////////////////////
	// compare tasks and commit monitor
	////////////////////////////////////////

	task automatic check_reg_idx(input string name, input logic [REG_IDX_W-1:0] expected,
		input logic [REG_IDX_W-1:0] actual);
		if (actual !== expected) begin
			errors++;
			$display("error %s: commit_rd expected %0d actual %0d", name, expected, actual);
		end
	endtask

	task automatic check_value(input string name, input logic [XLEN-1:0] expected,
		input logic [XLEN-1:0] actual);
		if (actual !== expected) begin
			errors++;
			$display("error %s: commit_value expected %h actual %h", name, expected, actual);
		end
	endtask

	// commit outputs settle well before the falling edge
	always @(negedge clock) begin
		if (!reset && commit_valid) begin
			commit_count++;
			if (exp_rd_q.size() == 0) begin
				errors++;
				$display("%s: commit seen with no instruction outstanding", test_name);
			end else begin
				check_reg_idx(test_name, exp_rd_q.pop_front(), commit_rd);
				check_value(test_name, exp_val_q.pop_front(), commit_value);
			end
		end
	end

	////////////////////////////////////////
	// stimulus
	////////////////////////////////////////

	task automatic report_timeout(input string what);
		timeouts++;
		timed_out = 1'b1;
		$display("timeout in %s: %s within %0d cycles", test_name, what, TIMEOUT_CYCLES);
	endtask

	task automatic wait_reset_release();
		int waited;
		waited = 0;
		@(posedge clock);
		while (reset && waited < TIMEOUT_CYCLES) begin
			@(posedge clock);
			waited++;
		end
		if (reset)
			report_timeout("reset was never released");
		#1;
	endtask

	// valid stays high on return, next call or an idle gap decides
	task automatic send_inst(input logic [31:0] word);
		int   waited;
		logic accepted;
		waited   = 0;
		accepted = 1'b0;
		if (!timed_out) begin
			inst_valid = 1'b1;
			inst       = word;
			while (!accepted && waited < TIMEOUT_CYCLES) begin
				// ready is registered state, sample it before the edge
				@(negedge clock);
				accepted = inst_ready;
				if (!inst_ready)
					stall_cycles++;
				@(posedge clock);
				#1;
				waited++;
			end
			if (accepted) begin
				accepted_count++;
				record_expected(word);
			end else begin
				report_timeout("instruction was not accepted");
			end
		end
	endtask

	task automatic send_li(input logic [REG_IDX_W-1:0] rd, input logic [15:0] imm);
		send_inst(make_inst(OP_LI, rd, 3'd0, 3'd0, imm));
	endtask

	task automatic send_alu(input logic [3:0] code, input logic [REG_IDX_W-1:0] rd,
		input logic [REG_IDX_W-1:0] rs1, input logic [REG_IDX_W-1:0] rs2);
		send_inst(make_inst(code, rd, rs1, rs2, 16'h0000));
	endtask

	task automatic idle_cycles(input int n);
		inst_valid = 1'b0;
		repeat (n) @(posedge clock);
		#1;
	endtask

	task automatic drain_commits();
		int waited;
		waited = 0;
		if (!timed_out) begin
			inst_valid = 1'b0;
			while (exp_rd_q.size() != 0 && waited < TIMEOUT_CYCLES) begin
				@(posedge clock);
				#1;
				waited++;
			end
			if (exp_rd_q.size() != 0)
				report_timeout("outstanding commits did not drain");
		end
	endtask

	////////////////////////////////////////
	// directed tests
	////////////////////////////////////////

	task automatic test_load_immediate();
		logic [15:0] imms [ARCH_REGS];
		imms = '{16'h7fff, 16'h8000, 16'hffff, 16'h0001, 16'h1234, 16'hedcb, 16'h0000,
			16'hc350};
		test_name = "test_load_immediate";
		for (int r = 0; r < ARCH_REGS; r++)
			send_li(REG_IDX_W'(r), imms[r]);
		drain_commits();
	endtask

	// back to back raw hazards through r1, plus a waw
	task automatic test_dependency_chain();
		test_name = "test_dependency_chain";
		send_li(3'd1, 16'd5);
		send_li(3'd2, 16'd3);
		send_alu(OP_ADD, 3'd1, 3'd1, 3'd2);
		send_alu(OP_SLL, 3'd1, 3'd1, 3'd2);
		send_alu(OP_MUL, 3'd1, 3'd1, 3'd1);
		send_alu(OP_SUB, 3'd1, 3'd1, 3'd2);
		send_alu(OP_XOR, 3'd1, 3'd2, 3'd1);
		send_alu(OP_SRL, 3'd1, 3'd1, 3'd2);
		send_alu(OP_OR, 3'd1, 3'd1, 3'd1);
		send_alu(OP_AND, 3'd3, 3'd1, 3'd2);
		send_li(3'd1, 16'hfff9);
		send_alu(OP_ADD, 3'd4, 3'd1, 3'd3);
		send_alu(OP_ADD, 3'd1, 3'd4, 3'd1);
		drain_commits();
	endtask

	task automatic test_all_ops();
		logic [3:0] codes [10];
		codes = '{OP_LI, OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLL, OP_SRL, OP_MUL,
			4'hf};
		test_name = "test_all_ops";
		for (int round = 0; round < 3; round++) begin
			for (int i = 0; i < 10; i++) begin
				send_li(3'd2, 16'($random(seed)));
				send_li(3'd3, 16'($random(seed)));
				send_inst(make_inst(codes[i], 3'd4, 3'd2, 3'd3, 16'($random(seed))));
			end
			drain_commits();
		end
	endtask

	// mul chain parks in the RS while the unit is busy
	task automatic test_backpressure();
		int stalls_before;
		test_name     = "test_backpressure";
		stalls_before = stall_cycles;
		send_li(3'd1, 16'($random(seed)));
		send_li(3'd2, 16'($random(seed)));
		repeat (6) send_alu(OP_MUL, 3'd1, 3'd1, 3'd2);
		send_alu(OP_ADD, 3'd3, 3'd2, 3'd2);
		send_alu(OP_SUB, 3'd4, 3'd2, 3'd3);
		send_alu(OP_XOR, 3'd5, 3'd3, 3'd4);
		send_alu(OP_OR, 3'd6, 3'd2, 3'd1);
		send_alu(OP_AND, 3'd7, 3'd6, 3'd3);
		send_alu(OP_SLL, 3'd0, 3'd2, 3'd4);
		drain_commits();
		if (!timed_out && stall_cycles == stalls_before) begin
			errors++;
			$display("%s: inst_ready never went low with the RS full", test_name);
		end
	endtask

	task automatic test_random_stream();
		logic [31:0] rnd;
		int          accepted_before, commits_before;
		test_name       = "test_random_stream";
		accepted_before = accepted_count;
		commits_before  = commit_count;
		for (int n = 0; n < 60; n++) begin
			rnd = $random(seed);
			// code 9 lands on the unknown path
			send_inst(make_inst(4'(rnd[7:0] % 8'd10), rnd[10:8], rnd[13:11], rnd[16:14],
				16'($random(seed))));
			if (rnd[19:18] == 2'b00)
				idle_cycles(1 + int'(rnd[21:20]));
		end
		drain_commits();
		if (!timed_out && (commit_count - commits_before) != (accepted_count - accepted_before))
		begin
			errors++;
			$display("error %s: commit count expected %0d actual %0d", test_name,
				accepted_count - accepted_before, commit_count - commits_before);
		end
	endtask

	////////////////////////////////////////
	// main sequence
	////////////////////////////////////////

	initial begin
		inst_valid     = 1'b0;
		inst           = '0;
		seed           = 62257;
		errors         = 0;
		timeouts       = 0;
		accepted_count = 0;
		commit_count   = 0;
		stall_cycles   = 0;
		timed_out      = 1'b0;
		test_name      = "reset";
		for (int r = 0; r < ARCH_REGS; r++)
			model_regs[r] = '0;
		wait_reset_release();
		test_load_immediate();
		test_dependency_chain();
		test_all_ops();
		test_backpressure();
		test_random_stream();
		$display("done: %0d errors, %0d timeouts, %0d commits", errors, timeouts,
			commit_count);
		if (errors == 0 && timeouts == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: vlog.f
hdl/core_pkg.sv
hdl/dispatch_stage.sv
hdl/map_table.sv
hdl/reservation_station.sv
hdl/exec_unit.sv
hdl/reorder_buffer.sv
hdl/regfile.sv
hdl/ooo_core.sv
testbench/tb_clock_gen.sv
testbench/tb_ooo_core.sv

// File: Makefile
SIM       := verilator
FLAGS     := --binary --timing --assert -Wno-fatal -j 0
TOP       := tb_ooo_core
FILELIST  := vlog.f
BUILD_DIR := obj_dir
PASS_MSG  := ALL TESTS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
